//--- src/receiver_ctrl_pkg.sv
`default_nettype none

package receiver_ctrl_pkg;

    // bus byte address and register word address
    localparam int AXI_ADDR_WIDTH = 11;
    localparam int REG_ADDR_WIDTH = 9;
    localparam int REG_DATA_WIDTH = 32;

    // physical cell id runs up to 3 * 335 + 2
    localparam int N_ID_MAX = 1007;
    localparam int N_ID_WIDTH = $clog2(N_ID_MAX + 1);
    localparam int LOCK_COUNT_WIDTH = 16;

    typedef logic [AXI_ADDR_WIDTH-1:0]   axi_addr_t;
    typedef logic [REG_ADDR_WIDTH-1:0]   reg_addr_t;
    typedef logic [REG_DATA_WIDTH-1:0]   reg_data_t;
    typedef logic [N_ID_WIDTH-1:0]       n_id_t;
    typedef logic [1:0]                  n_id_2_t;
    typedef logic [LOCK_COUNT_WIDTH-1:0] lock_count_t;

    typedef enum logic [1:0] {
        FS_SEARCH    = 2'd0,
        FS_PSS_FOUND = 2'd1,
        FS_SSS_FOUND = 2'd2,
        FS_LOCKED    = 2'd3
    } fs_state_e;

    typedef struct packed {
        fs_state_e   fs_state;
        reg_data_t   rx_signal;
        n_id_2_t     n_id_2;
        n_id_t       n_id;
        lock_count_t lock_count;
    } rx_status_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } reg_req_t;

    localparam reg_data_t PCORE_VERSION = 32'h00040069;
    localparam reg_data_t REGMAP_MAGIC  = "RX~~";
    localparam reg_data_t REGMAP_FILL   = 32'h69696969;

    localparam reg_addr_t REG_VERSION    = 9'd0;
    localparam reg_addr_t REG_ID         = 9'd1;
    localparam reg_addr_t REG_RESERVED   = 9'd2;
    localparam reg_addr_t REG_MAGIC      = 9'd3;
    localparam reg_addr_t REG_FILL       = 9'd4;
    localparam reg_addr_t REG_FS_STATE   = 9'd5;
    localparam reg_addr_t REG_RX_SIGNAL  = 9'd6;
    localparam reg_addr_t REG_N_ID_2     = 9'd7;
    localparam reg_addr_t REG_N_ID       = 9'd8;
    localparam reg_addr_t REG_LOCK_COUNT = 9'd9;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- src/rx_status_capture.sv
`timescale 1ns/100ps
`default_nettype none

module rx_status_capture (
    input  wire                            clk_i,
    input  wire                            reset_ni,

    // levels from the frame sync and the AGC path
    input  wire receiver_ctrl_pkg::fs_state_e fs_state_i,
    input  wire receiver_ctrl_pkg::reg_data_t rx_signal_i,

    // detector results, each qualified by a one-cycle strobe
    input  wire receiver_ctrl_pkg::n_id_2_t   n_id_2_i,
    input  wire                            n_id_2_valid_i,
    input  wire receiver_ctrl_pkg::n_id_t     n_id_i,
    input  wire                            n_id_valid_i,

    output receiver_ctrl_pkg::rx_status_t  status_o
);

    receiver_ctrl_pkg::rx_status_t status_q;
    logic                          lock_entry;
    logic                          lock_full;

    // status_q.fs_state is the state seen on the previous cycle
    assign lock_entry = (fs_state_i == receiver_ctrl_pkg::FS_LOCKED) &&
                        (status_q.fs_state != receiver_ctrl_pkg::FS_LOCKED);

    // counter holds at all ones
    assign lock_full = &status_q.lock_count;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            status_q.fs_state   <= receiver_ctrl_pkg::FS_SEARCH;
            status_q.rx_signal  <= '0;
            status_q.n_id_2     <= '0;
            status_q.n_id       <= '0;
            status_q.lock_count <= '0;
        end else begin
            status_q.fs_state  <= fs_state_i;
            status_q.rx_signal <= rx_signal_i;

            // cell id values stay until the detector reports again
            if (n_id_2_valid_i) begin
                status_q.n_id_2 <= n_id_2_i;
            end
            if (n_id_valid_i) begin
                status_q.n_id <= n_id_i;
            end

            if (lock_entry && !lock_full) begin
                status_q.lock_count <= status_q.lock_count + 1'b1;
            end
        end
    end

    assign status_o = status_q;

endmodule

`default_nettype wire

//--- src/receiver_regmap.sv
`timescale 1ns/100ps
`default_nettype none

module receiver_regmap #(
    parameter int unsigned ID = 0
) (
    input  wire                            clk_i,
    input  wire                            reset_ni,

    input  wire receiver_ctrl_pkg::rx_status_t status_i,

    // write side
    input  wire receiver_ctrl_pkg::reg_req_t   wreq_i,
    output logic                           wack_o,

    // read side
    input  wire receiver_ctrl_pkg::reg_req_t   rreq_i,
    output receiver_ctrl_pkg::reg_data_t   rdata_o,
    output logic                           rack_o
);

    receiver_ctrl_pkg::reg_data_t rword;
    receiver_ctrl_pkg::reg_data_t rdata_q;
    logic                         rack_q;
    logic                         wack_q;

    // acknowledge one cycle after each request
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rack_q <= 1'b0;
            wack_q <= 1'b0;
        end else begin
            rack_q <= rreq_i.valid;
            // no register here is writable, a write only gets its ack
            wack_q <= wreq_i.valid;
        end
    end

    // read decode
    always_comb begin
        rword = '0;
        case (rreq_i.addr)
            receiver_ctrl_pkg::REG_VERSION: begin
                rword = receiver_ctrl_pkg::PCORE_VERSION;
            end
            receiver_ctrl_pkg::REG_ID: begin
                rword = receiver_ctrl_pkg::reg_data_t'(ID);
            end
            receiver_ctrl_pkg::REG_RESERVED: begin
                rword = '0;
            end
            receiver_ctrl_pkg::REG_MAGIC: begin
                rword = receiver_ctrl_pkg::REGMAP_MAGIC;
            end
            receiver_ctrl_pkg::REG_FILL: begin
                rword = receiver_ctrl_pkg::REGMAP_FILL;
            end
            // live status, zero extended to the word
            receiver_ctrl_pkg::REG_FS_STATE: begin
                rword = receiver_ctrl_pkg::reg_data_t'(status_i.fs_state);
            end
            receiver_ctrl_pkg::REG_RX_SIGNAL: begin
                rword = status_i.rx_signal;
            end
            receiver_ctrl_pkg::REG_N_ID_2: begin
                rword = receiver_ctrl_pkg::reg_data_t'(status_i.n_id_2);
            end
            receiver_ctrl_pkg::REG_N_ID: begin
                rword = receiver_ctrl_pkg::reg_data_t'(status_i.n_id);
            end
            receiver_ctrl_pkg::REG_LOCK_COUNT: begin
                rword = receiver_ctrl_pkg::reg_data_t'(status_i.lock_count);
            end
            default: begin
                rword = '0;
            end
        endcase
    end

    // word is sampled with the request and presented with rack
    always_ff @(posedge clk_i) begin
        if (rreq_i.valid) begin
            rdata_q <= rword;
        end
    end

    assign rdata_o = rdata_q;
    assign rack_o  = rack_q;
    assign wack_o  = wack_q;

endmodule

`default_nettype wire

//--- src/axi_lite_interface.sv
`timescale 1ns/100ps
`default_nettype none

module axi_lite_interface (
    input  wire                            clk_i,
    input  wire                            reset_ni,

    // write address channel
    input  wire receiver_ctrl_pkg::axi_addr_t s_axi_awaddr_i,
    input  wire                            s_axi_awvalid_i,
    output logic                           s_axi_awready_o,

    // write data channel, strobes are not supported
    input  wire receiver_ctrl_pkg::reg_data_t s_axi_wdata_i,
    input  wire [3:0]                      s_axi_wstrb_i,
    input  wire                            s_axi_wvalid_i,
    output logic                           s_axi_wready_o,

    // write response channel
    output logic [1:0]                     s_axi_bresp_o,
    output logic                           s_axi_bvalid_o,
    input  wire                            s_axi_bready_i,

    // read address channel
    input  wire receiver_ctrl_pkg::axi_addr_t s_axi_araddr_i,
    input  wire                            s_axi_arvalid_i,
    output logic                           s_axi_arready_o,

    // read data channel
    output receiver_ctrl_pkg::reg_data_t   s_axi_rdata_o,
    output logic [1:0]                     s_axi_rresp_o,
    output logic                           s_axi_rvalid_o,
    input  wire                            s_axi_rready_i,

    // register request side
    output receiver_ctrl_pkg::reg_req_t    wreq_o,
    input  wire                            wack_i,
    output receiver_ctrl_pkg::reg_req_t    rreq_o,
    input  wire receiver_ctrl_pkg::reg_data_t rdata_i,
    input  wire                            rack_i
);

    typedef enum logic [1:0] {W_IDLE, W_REQ, W_WAIT, W_RESP} w_state_e;
    typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT, R_RESP} r_state_e;

    w_state_e                     w_state;
    r_state_e                     r_state;
    logic                         w_ready_q;
    logic                         ar_ready_q;
    receiver_ctrl_pkg::reg_addr_t waddr_q;
    receiver_ctrl_pkg::reg_data_t wdata_q;
    receiver_ctrl_pkg::reg_addr_t raddr_q;
    receiver_ctrl_pkg::reg_data_t rdata_q;

    // write path, aw and w are taken together in one handshake
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            w_state   <= W_IDLE;
            w_ready_q <= 1'b0;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (w_ready_q) begin
                        // valids are held, so this edge is the handshake
                        w_ready_q <= 1'b0;
                        w_state   <= W_REQ;
                    end else if (s_axi_awvalid_i && s_axi_wvalid_i) begin
                        w_ready_q <= 1'b1;
                    end
                end
                W_REQ: begin
                    w_state <= W_WAIT;
                end
                W_WAIT: begin
                    if (wack_i) begin
                        w_state <= W_RESP;
                    end
                end
                default: begin
                    if (s_axi_bready_i) begin
                        w_state <= W_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_state == W_IDLE && w_ready_q) begin
            waddr_q <= s_axi_awaddr_i[receiver_ctrl_pkg::AXI_ADDR_WIDTH-1:2];
            wdata_q <= s_axi_wdata_i;
        end
    end

    // read path
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            r_state    <= R_IDLE;
            ar_ready_q <= 1'b0;
        end else begin
            case (r_state)
                R_IDLE: begin
                    if (ar_ready_q) begin
                        ar_ready_q <= 1'b0;
                        r_state    <= R_REQ;
                    end else if (s_axi_arvalid_i) begin
                        ar_ready_q <= 1'b1;
                    end
                end
                R_REQ: begin
                    r_state <= R_WAIT;
                end
                R_WAIT: begin
                    if (rack_i) begin
                        r_state <= R_RESP;
                    end
                end
                default: begin
                    if (s_axi_rready_i) begin
                        r_state <= R_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (r_state == R_IDLE && ar_ready_q) begin
            raddr_q <= s_axi_araddr_i[receiver_ctrl_pkg::AXI_ADDR_WIDTH-1:2];
        end
        // data stays put while rvalid waits for rready
        if (r_state == R_WAIT && rack_i) begin
            rdata_q <= rdata_i;
        end
    end

    // requests last exactly the one cycle spent in the REQ state
    always_comb begin
        wreq_o.valid = (w_state == W_REQ);
        wreq_o.addr  = waddr_q;
        wreq_o.data  = wdata_q;
        rreq_o.valid = (r_state == R_REQ);
        rreq_o.addr  = raddr_q;
        rreq_o.data  = '0;
    end

    assign s_axi_awready_o = w_ready_q;
    assign s_axi_wready_o  = w_ready_q;
    assign s_axi_bvalid_o  = (w_state == W_RESP);
    assign s_axi_bresp_o   = receiver_ctrl_pkg::AXI_RESP_OKAY;

    assign s_axi_arready_o = ar_ready_q;
    assign s_axi_rvalid_o  = (r_state == R_RESP);
    assign s_axi_rdata_o   = rdata_q;
    assign s_axi_rresp_o   = receiver_ctrl_pkg::AXI_RESP_OKAY;

endmodule

`default_nettype wire

//--- src/receiver_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module receiver_ctrl_top #(
    parameter int unsigned ID = 0
) (
    input  wire                            clk_i,
    input  wire                            reset_ni,

    // AXI-lite slave
    input  wire receiver_ctrl_pkg::axi_addr_t s_axi_awaddr_i,
    input  wire                            s_axi_awvalid_i,
    output logic                           s_axi_awready_o,
    input  wire receiver_ctrl_pkg::reg_data_t s_axi_wdata_i,
    input  wire [3:0]                      s_axi_wstrb_i,
    input  wire                            s_axi_wvalid_i,
    output logic                           s_axi_wready_o,
    output logic [1:0]                     s_axi_bresp_o,
    output logic                           s_axi_bvalid_o,
    input  wire                            s_axi_bready_i,
    input  wire receiver_ctrl_pkg::axi_addr_t s_axi_araddr_i,
    input  wire                            s_axi_arvalid_i,
    output logic                           s_axi_arready_o,
    output receiver_ctrl_pkg::reg_data_t   s_axi_rdata_o,
    output logic [1:0]                     s_axi_rresp_o,
    output logic                           s_axi_rvalid_o,
    input  wire                            s_axi_rready_i,

    // receiver status
    input  wire receiver_ctrl_pkg::fs_state_e fs_state_i,
    input  wire receiver_ctrl_pkg::reg_data_t rx_signal_i,
    input  wire receiver_ctrl_pkg::n_id_2_t   n_id_2_i,
    input  wire                            n_id_2_valid_i,
    input  wire receiver_ctrl_pkg::n_id_t     n_id_i,
    input  wire                            n_id_valid_i
);

    receiver_ctrl_pkg::rx_status_t status;
    receiver_ctrl_pkg::reg_req_t   wreq;
    receiver_ctrl_pkg::reg_req_t   rreq;
    receiver_ctrl_pkg::reg_data_t  rdata;
    logic                          wack;
    logic                          rack;

    rx_status_capture u_capture (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .fs_state_i     (fs_state_i),
        .rx_signal_i    (rx_signal_i),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .status_o       (status)
    );

    receiver_regmap #(
        .ID (ID)
    ) u_regmap (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .status_i (status),
        .wreq_i   (wreq),
        .wack_o   (wack),
        .rreq_i   (rreq),
        .rdata_o  (rdata),
        .rack_o   (rack)
    );

    axi_lite_interface u_axi (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .wreq_o          (wreq),
        .wack_i          (wack),
        .rreq_o          (rreq),
        .rdata_i         (rdata),
        .rack_i          (rack)
    );

endmodule

`default_nettype wire

//--- bench/receiver_ctrl_props.sv
`timescale 1ns/100ps
`default_nettype none

module receiver_ctrl_props (
    input wire                               clk_i,
    input wire                               reset_ni,
    input wire                               s_axi_bvalid_o,
    input wire                               s_axi_bready_i,
    input wire                               s_axi_arvalid_i,
    input wire                               s_axi_arready_o,
    input wire                               s_axi_rvalid_o,
    input wire                               s_axi_rready_i,
    input wire receiver_ctrl_pkg::reg_data_t s_axi_rdata_o
);

    // write response waits for the master
    bvalid_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
        else $error("bvalid dropped before bready");

    // read response and its data wait for the master
    rvalid_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
        else $error("rvalid or rdata changed before rready");

    // one read in flight at a time
    no_ar_during_r: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axi_rvalid_o |-> !(s_axi_arvalid_i && s_axi_arready_o))
        else $error("read address accepted while rvalid was high");

    reset_clears_resp: assert property (@(posedge clk_i)
        !reset_ni |=> !s_axi_bvalid_o && !s_axi_rvalid_o)
        else $error("bvalid or rvalid high after reset");

endmodule

bind axi_lite_interface receiver_ctrl_props u_props (.*);

`default_nettype wire

//--- bench/receiver_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module receiver_ctrl_tb;

    localparam int WAIT_LIMIT = 50;

    logic                           clk_i = 1'b0;
    logic                           reset_ni;
    receiver_ctrl_pkg::axi_addr_t   awaddr;
    logic                           awvalid;
    logic                           awready;
    receiver_ctrl_pkg::reg_data_t   wdata;
    logic [3:0]                     wstrb;
    logic                           wvalid;
    logic                           wready;
    logic [1:0]                     bresp;
    logic                           bvalid;
    logic                           bready;
    receiver_ctrl_pkg::axi_addr_t   araddr;
    logic                           arvalid;
    logic                           arready;
    receiver_ctrl_pkg::reg_data_t   rdata;
    logic [1:0]                     rresp;
    logic                           rvalid;
    logic                           rready;
    receiver_ctrl_pkg::fs_state_e   fs_state;
    receiver_ctrl_pkg::reg_data_t   rx_signal;
    receiver_ctrl_pkg::n_id_2_t     n_id_2;
    logic                           n_id_2_valid;
    receiver_ctrl_pkg::n_id_t       n_id;
    logic                           n_id_valid;

    // receiver model of the values the DUT should be holding
    receiver_ctrl_pkg::n_id_2_t     model_n_id_2;
    receiver_ctrl_pkg::n_id_t       model_n_id;
    int                             model_locks = 0;

    logic [31:0]                    rng = 32'hb5fa875d;
    string                          test_name = "reset";
    int                             errors = 0;
    int                             timeouts = 0;

    always #2 clk_i = ~clk_i;

    receiver_ctrl_top #(
        .ID (5)
    ) u_dut (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axi_awaddr_i  (awaddr),
        .s_axi_awvalid_i (awvalid),
        .s_axi_awready_o (awready),
        .s_axi_wdata_i   (wdata),
        .s_axi_wstrb_i   (wstrb),
        .s_axi_wvalid_i  (wvalid),
        .s_axi_wready_o  (wready),
        .s_axi_bresp_o   (bresp),
        .s_axi_bvalid_o  (bvalid),
        .s_axi_bready_i  (bready),
        .s_axi_araddr_i  (araddr),
        .s_axi_arvalid_i (arvalid),
        .s_axi_arready_o (arready),
        .s_axi_rdata_o   (rdata),
        .s_axi_rresp_o   (rresp),
        .s_axi_rvalid_o  (rvalid),
        .s_axi_rready_i  (rready),
        .fs_state_i      (fs_state),
        .rx_signal_i     (rx_signal),
        .n_id_2_i        (n_id_2),
        .n_id_2_valid_i  (n_id_2_valid),
        .n_id_i          (n_id),
        .n_id_valid_i    (n_id_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // outputs are settled and inputs are driven 1 ns after the edge
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic expect_word(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in %s: %s never came", test_name, what);
        timeouts++;
    endtask

    // completes the ar handshake for a raised arvalid and takes the data
    task automatic finish_read(output receiver_ctrl_pkg::reg_data_t data);
        int cycles;
        cycles = 0;
        while (!arready && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!arready) begin
            report_timeout("arready");
        end
        // arready high now means the next edge is the ar handshake
        tick();
        arvalid = 1'b0;
        cycles = 0;
        while (!rvalid && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!rvalid) begin
            report_timeout("rvalid");
        end
        data = rdata;
        expect_word("rresp", 32'd0, 32'(rresp));
        tick();
    endtask

    task automatic axi_read(input receiver_ctrl_pkg::reg_addr_t addr,
                            output receiver_ctrl_pkg::reg_data_t data);
        araddr  = {addr, 2'b00};
        arvalid = 1'b1;
        finish_read(data);
    endtask

    task automatic read_check(input string what, input receiver_ctrl_pkg::reg_addr_t addr,
                              input logic [31:0] exp);
        receiver_ctrl_pkg::reg_data_t data;
        axi_read(addr, data);
        expect_word(what, exp, data);
    endtask

    task automatic axi_write(input receiver_ctrl_pkg::reg_addr_t addr,
                             input receiver_ctrl_pkg::reg_data_t data,
                             input int stall);
        int cycles;
        awaddr  = {addr, 2'b00};
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cycles  = 0;
        while (!awready && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!awready) begin
            report_timeout("awready");
        end
        expect_word("wready", 32'd1, 32'(wready));
        tick();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cycles  = 0;
        while (!bvalid && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!bvalid) begin
            report_timeout("bvalid");
        end
        expect_word("bresp", 32'd0, 32'(bresp));
        // master holds off the response for a few cycles
        if (stall > 0) begin
            bready = 1'b0;
            repeat (stall) begin
                tick();
                if (!bvalid) begin
                    $display("%s: bvalid dropped while bready was low", test_name);
                    errors++;
                end
            end
            bready = 1'b1;
        end
        tick();
    endtask

    // a lock event is any entry into FS_LOCKED from another state
    task automatic set_fs_state(input receiver_ctrl_pkg::fs_state_e s);
        if (s == receiver_ctrl_pkg::FS_LOCKED && fs_state != receiver_ctrl_pkg::FS_LOCKED) begin
            model_locks++;
        end
        fs_state = s;
        tick();
        tick();
    endtask

    task automatic check_identification();
        read_check("version", 9'd0, 32'h00040069);
        read_check("id", 9'd1, 32'd5);
        read_check("reserved", 9'd2, 32'd0);
        read_check("magic", 9'd3, 32'h52587e7e);
        read_check("fill", 9'd4, 32'h69696969);
    endtask

    task automatic identification_regs();
        test_name = "identification";
        check_identification();
        read_check("unmapped", 9'h1f, 32'd0);
    endtask

    task automatic live_status_readback();
        test_name = "live_status";
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            rx_signal = rng;
            set_fs_state(receiver_ctrl_pkg::fs_state_e'(2'(i)));
            read_check("fs_state", receiver_ctrl_pkg::REG_FS_STATE, 32'(i));
            read_check("rx_signal", receiver_ctrl_pkg::REG_RX_SIGNAL, rx_signal);
        end
    endtask

    task automatic strobed_cell_id_hold();
        test_name = "strobed_cell_id";
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            n_id_2 = receiver_ctrl_pkg::n_id_2_t'(rng % 3);
            n_id = receiver_ctrl_pkg::n_id_t'((rng >> 8) % 1008);
            n_id_2_valid = 1'b1;
            n_id_valid = 1'b1;
            tick();
            n_id_2_valid = 1'b0;
            n_id_valid = 1'b0;
            model_n_id_2 = n_id_2;
            model_n_id = n_id;
            // new values without a strobe must not reach the registers
            n_id_2 = receiver_ctrl_pkg::n_id_2_t'((32'(n_id_2) + 1) % 3);
            n_id = receiver_ctrl_pkg::n_id_t'((32'(n_id) + 500) % 1008);
            tick();
            tick();
            read_check("n_id_2", receiver_ctrl_pkg::REG_N_ID_2, 32'(model_n_id_2));
            read_check("n_id", receiver_ctrl_pkg::REG_N_ID, 32'(model_n_id));
        end
    endtask

    task automatic lock_event_count();
        receiver_ctrl_pkg::fs_state_e seq [10] = '{
            receiver_ctrl_pkg::FS_SEARCH, receiver_ctrl_pkg::FS_PSS_FOUND,
            receiver_ctrl_pkg::FS_SSS_FOUND, receiver_ctrl_pkg::FS_LOCKED,
            receiver_ctrl_pkg::FS_LOCKED, receiver_ctrl_pkg::FS_SSS_FOUND,
            receiver_ctrl_pkg::FS_LOCKED, receiver_ctrl_pkg::FS_SEARCH,
            receiver_ctrl_pkg::FS_LOCKED, receiver_ctrl_pkg::FS_LOCKED
        };
        test_name = "lock_counting";
        foreach (seq[i]) begin
            set_fs_state(seq[i]);
        end
        read_check("lock_count", receiver_ctrl_pkg::REG_LOCK_COUNT, 32'(model_locks));
    endtask

    task automatic ignored_writes();
        test_name = "writes_ignored";
        for (int i = 0; i < 10; i++) begin
            rng = xorshift32(rng);
            axi_write(receiver_ctrl_pkg::reg_addr_t'(i), rng, i % 3);
        end
        check_identification();
        read_check("lock_count", receiver_ctrl_pkg::REG_LOCK_COUNT, 32'(model_locks));
    endtask

    task automatic read_back_pressure();
        receiver_ctrl_pkg::reg_data_t data;
        int cycles;
        test_name = "back_pressure";
        rready  = 1'b0;
        araddr  = {receiver_ctrl_pkg::REG_MAGIC, 2'b00};
        arvalid = 1'b1;
        cycles  = 0;
        while (!arready && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!arready) begin
            report_timeout("arready");
        end
        tick();
        arvalid = 1'b0;
        cycles  = 0;
        while (!rvalid && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!rvalid) begin
            report_timeout("rvalid");
        end
        // second read queues up behind the stalled response
        araddr  = {receiver_ctrl_pkg::REG_FILL, 2'b00};
        arvalid = 1'b1;
        repeat (6) begin
            tick();
            if (!rvalid) begin
                $display("%s: rvalid dropped while rready was low", test_name);
                errors++;
            end
            if (arready) begin
                $display("%s: second read accepted while rvalid was high", test_name);
                errors++;
            end
            expect_word("stalled rdata", 32'h52587e7e, rdata);
        end
        rready = 1'b1;
        tick();
        finish_read(data);
        expect_word("second read", 32'h69696969, data);
    endtask

    initial begin
        reset_ni     = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'hf;
        wvalid       = 1'b0;
        bready       = 1'b1;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b1;
        fs_state     = receiver_ctrl_pkg::FS_SEARCH;
        rx_signal    = '0;
        n_id_2       = '0;
        n_id_2_valid = 1'b0;
        n_id         = '0;
        n_id_valid   = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        tick();

        identification_regs();
        live_status_readback();
        strobed_cell_id_hold();
        lock_event_count();
        ignored_writes();
        read_back_pressure();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
src/receiver_ctrl_pkg.sv
src/rx_status_capture.sv
src/receiver_regmap.sv
src/axi_lite_interface.sv
src/receiver_ctrl_top.sv
bench/receiver_ctrl_props.sv
bench/receiver_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= receiver_ctrl_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILE_LIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
